/* common/predecPkg.sv */
`default_nettype none

package predecPkg;

  localparam int unsigned classW = 13;

  // class vector bit positions
  localparam int unsigned clsAlu     = 0;
  localparam int unsigned clsShift   = 1;
  localparam int unsigned clsMul     = 2;
  localparam int unsigned clsLoad    = 3;
  localparam int unsigned clsStore   = 4;
  localparam int unsigned clsStore2  = 5; // store data from fp regfile
  localparam int unsigned clsFpu     = 6;
  localparam int unsigned clsLoadFpu = 7;
  localparam int unsigned clsSys     = 8;
  localparam int unsigned clsJump    = 9;
  localparam int unsigned clsIndir   = 10;
  localparam int unsigned clsBranch  = 11;
  localparam int unsigned clsPos0    = 12;

  // major opcodes
  localparam logic [6:0] opLoad    = 7'b0000011;
  localparam logic [6:0] opLoadFp  = 7'b0000111;
  localparam logic [6:0] opMiscMem = 7'b0001111;
  localparam logic [6:0] opOpImm   = 7'b0010011;
  localparam logic [6:0] opAuipc   = 7'b0010111;
  localparam logic [6:0] opOpImm32 = 7'b0011011;
  localparam logic [6:0] opStore   = 7'b0100011;
  localparam logic [6:0] opStoreFp = 7'b0100111;
  localparam logic [6:0] opOp      = 7'b0110011;
  localparam logic [6:0] opLui     = 7'b0110111;
  localparam logic [6:0] opOp32    = 7'b0111011;
  localparam logic [6:0] opFma     = 7'b1000011; // four fma opcodes share [6:4]
  localparam logic [6:0] opOpFp    = 7'b1010011;
  localparam logic [6:0] opBranch  = 7'b1100011;
  localparam logic [6:0] opJalr    = 7'b1100111;
  localparam logic [6:0] opJal     = 7'b1101111;
  localparam logic [6:0] opSystem  = 7'b1110011;

  localparam logic [4:0] linkX1 = 5'd1;
  localparam logic [4:0] linkX5 = 5'd5;

  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } rv;
    struct packed {
      logic [15:0] upper; // zero for compressed
      logic [2:0]  cFunct3;
      logic        cBit12;
      logic [4:0]  cRd;
      logic [4:0]  cRs2;
      logic [1:0]  cOp;
    } rvc;
  } instWord_u;

  typedef enum logic [1:0] {
    aligned  = 2'd0,
    heldHalf = 2'd1, // low half of a 32-bit inst held
    heldComp = 2'd2, // whole compressed inst held
    skipLow  = 2'd3
  } fetchState_e;

endpackage

`default_nettype wire

/* flist.f */
common/predecPkg.sv
predec/predecClass.sv
predec/predecLink.sv
hw/parcelAligner.sv
hw/fetchCtrl.sv
hw/pcCounter.sv
hw/predecTop.sv
tb/predecTop_sva.sv
tb/predecTb.sv

/* hw/fetchCtrl.sv */
`timescale 1ns/1ns
`default_nettype none

module fetchCtrl (
  input  logic clk,
  input  logic rst,
  input  logic redirect,
  input  logic redirectOdd,
  input  logic fetchValid,
  input  logic lowIsComp,
  input  logic highIsComp,
  input  logic heldIsComp,
  output logic fetchReady,
  output logic accept,
  output logic emit,
  output logic emitComp,
  output logic selHeld,
  output logic keepHigh
);
  import predecPkg::*;

  fetchState_e state;
  fetchState_e nextState;

  assign fetchReady = (state != heldComp);
  assign accept     = fetchValid && fetchReady && !redirect;
  assign emitComp   = selHeld ? heldIsComp : lowIsComp; // length from first parcel

  always_comb begin
    nextState = state;
    emit      = 1'b0;
    selHeld   = 1'b0;
    keepHigh  = 1'b0;
    if (redirect) begin
      nextState = redirectOdd ? skipLow : aligned;
    end else begin
      case (state)
        aligned: begin
          if (accept) begin
            emit = 1'b1;
            if (lowIsComp) begin
              keepHigh  = 1'b1;
              nextState = highIsComp ? heldComp : heldHalf;
            end
          end
        end
        heldHalf: begin
          if (accept) begin
            emit      = 1'b1;
            selHeld   = 1'b1;
            keepHigh  = 1'b1;
            nextState = highIsComp ? heldComp : heldHalf;
          end
        end
        heldComp: begin
          emit      = 1'b1; // no word taken this cycle
          selHeld   = 1'b1;
          nextState = aligned;
        end
        default: begin // skipLow
          if (accept) begin
            keepHigh  = 1'b1;
            nextState = highIsComp ? heldComp : heldHalf;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) state <= aligned;
    else state <= nextState;
  end

endmodule

`default_nettype wire

/* hw/parcelAligner.sv */
`timescale 1ns/1ns
`default_nettype none

module parcelAligner (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         redirect,
  input  logic [31:0]                  fetchWord,
  input  logic                         accept,
  input  logic                         emit,
  input  logic                         selHeld,
  input  logic                         keepHigh,
  input  logic [63:0]                  pc,
  input  logic [predecPkg::classW-1:0] classIn,
  input  logic                         isLnkIn,
  input  logic                         isRetIn,
  input  logic [1:0]                   lnk2In,
  output logic                         lowIsComp,
  output logic                         highIsComp,
  output logic                         heldIsComp,
  output predecPkg::instWord_u         instNow,
  output logic                         pos0,
  output logic                         instValid,
  output logic [31:0]                  instOut,
  output logic [63:0]                  instPc,
  output logic [predecPkg::classW-1:0] instClass,
  output logic                         isLnk,
  output logic                         isRet,
  output logic [1:0]                   lnk2
);

  logic [15:0] heldParcel;
  logic        heldValid;
  logic [15:0] lowParcel;
  logic [15:0] highParcel;
  logic [15:0] firstParcel;

  assign lowParcel  = fetchWord[15:0];
  assign highParcel = fetchWord[31:16];

  assign lowIsComp  = (lowParcel[1:0] != 2'b11);
  assign highIsComp = (highParcel[1:0] != 2'b11);
  assign heldIsComp = heldValid && (heldParcel[1:0] != 2'b11);

  assign firstParcel = selHeld ? heldParcel : lowParcel;
  assign pos0        = !selHeld;

  always_comb begin
    if (firstParcel[1:0] != 2'b11) instNow = {16'h0000, firstParcel}; // zero-extend rvc
    else if (selHeld) instNow = {lowParcel, heldParcel};              // straddles words
    else instNow = fetchWord;
  end

  always_ff @(posedge clk) begin
    if (accept && keepHigh) heldParcel <= highParcel;
  end

  always_ff @(posedge clk) begin
    if (rst || redirect) begin
      heldValid <= 1'b0;
    end else if (accept && keepHigh) begin
      heldValid <= 1'b1;
    end else if (emit && selHeld) begin
      heldValid <= 1'b0; // held parcel consumed
    end
  end

  always_ff @(posedge clk) begin
    if (rst) instValid <= 1'b0;
    else instValid <= emit;
  end

  always_ff @(posedge clk) begin
    if (emit) begin
      instOut   <= instNow;
      instPc    <= pc;
      instClass <= classIn;
      isLnk     <= isLnkIn;
      isRet     <= isRetIn;
      lnk2      <= lnk2In;
    end
  end

endmodule

`default_nettype wire

/* hw/pcCounter.sv */
`timescale 1ns/1ns
`default_nettype none

module pcCounter (
  input  logic        clk,
  input  logic        rst,
  input  logic        redirect,
  input  logic [63:0] redirectPc,
  input  logic        emit,
  input  logic        emitComp,
  output logic [63:0] pc
);

  logic [63:0] step;

  assign step = emitComp ? 64'd2 : 64'd4;

  // address of the next inst to emit
  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= 64'd0;
    end else if (redirect) begin
      pc <= redirectPc;
    end else if (emit) begin
      pc <= pc + step;
    end
  end

endmodule

`default_nettype wire

/* hw/predecTop.sv */
`timescale 1ns/1ns
`default_nettype none

module predecTop (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         fetchValid,
  input  logic [31:0]                  fetchWord,
  input  logic                         redirect,
  input  logic [63:0]                  redirectPc,
  output logic                         fetchReady,
  output logic                         instValid,
  output logic [31:0]                  instOut,
  output logic [63:0]                  instPc,
  output logic [predecPkg::classW-1:0] instClass,
  output logic                         isLnk,
  output logic                         isRet,
  output logic [1:0]                   lnk2
);
  import predecPkg::*;

  logic              accept;
  logic              emit;
  logic              emitComp;
  logic              selHeld;
  logic              keepHigh;
  logic              lowIsComp;
  logic              highIsComp;
  logic              heldIsComp;
  logic [63:0]       pc;
  instWord_u         instNow;
  logic              pos0;
  logic [classW-1:0] classNow; // combinational predecode
  logic              isLnkNow;
  logic              isRetNow;
  logic [1:0]        lnk2Now;

  pcCounter u_pcCounter (
    .clk(clk), .rst(rst), .redirect(redirect), .redirectPc(redirectPc),
    .emit(emit), .emitComp(emitComp), .pc(pc)
  );

  fetchCtrl u_fetchCtrl (
    .clk(clk), .rst(rst), .redirect(redirect), .redirectOdd(redirectPc[1]),
    .fetchValid(fetchValid), .lowIsComp(lowIsComp), .highIsComp(highIsComp),
    .heldIsComp(heldIsComp), .fetchReady(fetchReady), .accept(accept), .emit(emit),
    .emitComp(emitComp), .selHeld(selHeld), .keepHigh(keepHigh)
  );

  parcelAligner u_parcelAligner (
    .clk(clk), .rst(rst), .redirect(redirect), .fetchWord(fetchWord),
    .accept(accept), .emit(emit), .selHeld(selHeld), .keepHigh(keepHigh), .pc(pc),
    .classIn(classNow), .isLnkIn(isLnkNow), .isRetIn(isRetNow), .lnk2In(lnk2Now),
    .lowIsComp(lowIsComp), .highIsComp(highIsComp), .heldIsComp(heldIsComp),
    .instNow(instNow), .pos0(pos0), .instValid(instValid), .instOut(instOut),
    .instPc(instPc), .instClass(instClass), .isLnk(isLnk), .isRet(isRet), .lnk2(lnk2)
  );

  predecClass u_predecClass (.inst(instNow), .pos0(pos0), .instClass(classNow));

  predecLink u_predecLink (.inst(instNow), .isLnk(isLnkNow), .isRet(isRetNow), .lnk2(lnk2Now));

endmodule

`default_nettype wire

/* predec/predecClass.sv */
`timescale 1ns/1ns
`default_nettype none

module predecClass (
  input  predecPkg::instWord_u              inst,
  input  logic                              pos0,
  output logic [predecPkg::classW-1:0]      instClass
);
  import predecPkg::*;

  logic isComp;

  // legal funct7 for a shift, 6-bit shamt on rv64 op-imm
  function automatic logic shiftOk(input logic [2:0] funct3, input logic [6:0] funct7,
                                   input logic wideShamt);
    logic arith;
    logic upperZero;
    arith     = (funct3 == 3'b101) && (funct7[6:1] == 6'b010000);
    upperZero = (funct7[6:1] == 6'b000000);
    if (wideShamt) begin
      shiftOk = upperZero || arith;
    end else begin
      shiftOk = (funct7 == 7'b0000000) || (arith && !funct7[0]);
    end
  endfunction

  assign isComp = (inst.rvc.cOp != 2'b11);

  always_comb begin
    instClass = '0;
    if (isComp) begin
      case (inst.rvc.cOp)
        2'b00: begin
          if (inst.rvc.cFunct3 == 3'b000) instClass[clsAlu] = 1'b1; // c.addi4spn
          else if (inst.rvc.cFunct3[1:0] != 2'b00) begin
            if (inst.rvc.cFunct3[2]) instClass[clsStore] = 1'b1;
            else instClass[clsLoad] = 1'b1;
            if (inst.rvc.cFunct3 == 3'b001) instClass[clsLoadFpu] = 1'b1;
            if (inst.rvc.cFunct3 == 3'b101) instClass[clsStore2] = 1'b1;
          end
        end
        2'b01: begin
          case (inst.rvc.cFunct3)
            3'b100: begin
              if (inst.rvc.cRd[4:3] == 2'b00 || inst.rvc.cRd[4:3] == 2'b01) begin
                instClass[clsShift] = 1'b1; // c.srli, c.srai
              end else if (!(inst.rvc.cBit12 && inst.rvc.cRd[4:3] == 2'b11 &&
                             inst.rvc.cRs2[4])) begin
                instClass[clsAlu] = 1'b1;
              end
            end
            3'b101:         instClass[clsJump] = 1'b1;
            3'b110, 3'b111: instClass[clsBranch] = 1'b1;
            default:        instClass[clsAlu] = 1'b1; // addi, addiw, li, lui
          endcase
        end
        default: begin
          case (inst.rvc.cFunct3)
            3'b000: if (inst.rvc.cRd != 5'd0) instClass[clsShift] = 1'b1;
            3'b100: begin
              if (inst.rvc.cRs2 != 5'd0) begin
                if (inst.rvc.cBit12) instClass[clsAlu] = 1'b1;
                else instClass[clsMul] = 1'b1; // c.mv grouped with mul
              end else if (inst.rvc.cRd != 5'd0) begin
                instClass[clsIndir] = 1'b1;
              end else if (inst.rvc.cBit12) begin
                instClass[clsSys] = 1'b1;     // c.ebreak
              end
            end
            default: begin
              // stack ld/st, lwsp and ldsp need rd
              if (inst.rvc.cFunct3[2] || inst.rvc.cFunct3 == 3'b001 ||
                  inst.rvc.cRd != 5'd0) begin
                if (inst.rvc.cFunct3[2]) instClass[clsStore] = 1'b1;
                else instClass[clsLoad] = 1'b1;
                if (inst.rvc.cFunct3 == 3'b001) instClass[clsLoadFpu] = 1'b1;
                if (inst.rvc.cFunct3 == 3'b101) instClass[clsStore2] = 1'b1;
              end
            end
          endcase
        end
      endcase
    end else begin
      case (inst.rv.opcode)
        opLoad:   instClass[clsLoad] = 1'b1;
        opLoadFp: begin
          instClass[clsLoad]    = 1'b1;
          instClass[clsLoadFpu] = 1'b1;
        end
        opStore:  instClass[clsStore] = 1'b1;
        opStoreFp: begin
          instClass[clsStore]  = 1'b1;
          instClass[clsStore2] = 1'b1;
        end
        opOpImm, opOpImm32: begin
          if (inst.rv.funct3[1:0] == 2'b01 &&
              shiftOk(inst.rv.funct3, inst.rv.funct7, inst.rv.opcode == opOpImm)) begin
            instClass[clsShift] = 1'b1;
          end else begin
            instClass[clsAlu] = 1'b1;
          end
        end
        opOp, opOp32: begin
          if (inst.rv.funct7 == 7'b0000001) instClass[clsMul] = 1'b1;
          else if (inst.rv.funct3[1:0] == 2'b01 &&
                   shiftOk(inst.rv.funct3, inst.rv.funct7, 1'b0)) instClass[clsShift] = 1'b1;
          else instClass[clsAlu] = 1'b1;
        end
        opLui, opAuipc:      instClass[clsAlu] = 1'b1;
        opJal:               instClass[clsJump] = 1'b1;
        opJalr:              instClass[clsIndir] = 1'b1;
        opBranch:            instClass[clsBranch] = 1'b1;
        opOpFp:              instClass[clsFpu] = 1'b1;
        opSystem, opMiscMem: instClass[clsSys] = 1'b1;
        default: if (inst.rv.opcode[6:4] == opFma[6:4]) instClass[clsFpu] = 1'b1;
      endcase
    end
    instClass[clsPos0] = pos0;
  end

endmodule

`default_nettype wire

/* predec/predecLink.sv */
`timescale 1ns/1ns
`default_nettype none

module predecLink (
  input  predecPkg::instWord_u inst,
  output logic                 isLnk,
  output logic                 isRet,
  output logic [1:0]           lnk2
);
  import predecPkg::*;

  logic isComp;
  logic cJumpReg; // c.jr or c.jalr
  logic isJal;
  logic isJalr;

  function automatic logic [1:0] linkCode(input logic [4:0] regNum);
    linkCode = 2'b00;
    if (regNum == linkX1) linkCode = 2'b01;
    else if (regNum == linkX5) linkCode = 2'b10;
  endfunction

  assign isComp   = (inst.rvc.cOp != 2'b11);
  assign cJumpReg = (inst.rvc.cOp == 2'b10) && (inst.rvc.cFunct3 == 3'b100) &&
                    (inst.rvc.cRs2 == 5'd0) && (inst.rvc.cRd != 5'd0);
  assign isJal    = (inst.rv.opcode == opJal);
  assign isJalr   = (inst.rv.opcode == opJalr);

  always_comb begin
    isLnk = 1'b0;
    isRet = 1'b0;
    lnk2  = 2'b00;
    if (isComp) begin
      if (cJumpReg && inst.rvc.cBit12) begin
        isLnk = 1'b1; // c.jalr always writes x1
        lnk2  = 2'b01;
      end else if (cJumpReg && linkCode(inst.rvc.cRd) != 2'b00) begin
        isRet = 1'b1;
        lnk2  = linkCode(inst.rvc.cRd);
      end
    end else if ((isJal || isJalr) && linkCode(inst.rv.rd) != 2'b00) begin
      isLnk = 1'b1;
      lnk2  = linkCode(inst.rv.rd);
    end else if (isJalr && inst.rv.rd == 5'd0 && linkCode(inst.rv.rs1) != 2'b00) begin
      isRet = 1'b1;
      lnk2  = linkCode(inst.rv.rs1);
    end
  end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build and run the predecoder testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module predecTb -f flist.f; then
  echo "build failed"
  exit 1
fi

./obj_dir/VpredecTb > sim.log 2>&1
status=$?
cat sim.log

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Test failed" sim.log; then
  exit 1
fi

exit 0

/* tb/predecTb.sv */
`timescale 1ns/1ns
`default_nettype none

module predecTb;
  import predecPkg::*;

  logic              clk;
  logic              rst;
  logic              fetchValid;
  logic [31:0]       fetchWord;
  logic              redirect;
  logic [63:0]       redirectPc;
  logic              fetchReady;
  logic              instValid;
  logic [31:0]       instOut;
  logic [63:0]       instPc;
  logic [classW-1:0] instClass;
  logic              isLnk;
  logic              isRet;
  logic [1:0]        lnk2;

  // stimulus table with redirect markers in line
  logic [31:0]       tabInst[$];
  logic [classW-1:0] tabCls[$];
  logic              tabLnk[$];
  logic              tabRet[$];
  logic [1:0]        tabL2[$];
  logic              tabRedir[$];
  logic [63:0]       tabTarget[$];

  logic [15:0]       parcelBuf[$];
  logic [1:0]        parcelTag[$]; // 0 filler, 1 rvc, 2 low half, 3 high half
  logic              stimKind[$]; // 1 = redirect pulse
  logic [63:0]       stimData[$];
  logic              stimEmit[$];
  logic              stimHold[$];

  logic [31:0]       expInst[$];
  logic [classW-1:0] expCls[$];
  logic [63:0]       expPc[$];
  logic              expLnk[$];
  logic              expRet[$];
  logic [1:0]        expL2[$];

  int                errors;
  int                checkIdx;
  logic              tableReady;
  logic [31:0]       rndState;

  predecTop u_predecTop (
    .clk(clk), .rst(rst), .fetchValid(fetchValid), .fetchWord(fetchWord),
    .redirect(redirect), .redirectPc(redirectPc), .fetchReady(fetchReady),
    .instValid(instValid), .instOut(instOut), .instPc(instPc), .instClass(instClass),
    .isLnk(isLnk), .isRet(isRet), .lnk2(lnk2)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [classW-1:0] clsBit(input int unsigned idx);
    logic [classW-1:0] v;
    v = '0;
    v[idx] = 1'b1;
    return v;
  endfunction

  task automatic addInst(input logic [31:0] inst, input logic [classW-1:0] cls,
                         input logic lnk, input logic ret, input logic [1:0] l2);
    tabInst.push_back(inst);
    tabCls.push_back(cls);
    tabLnk.push_back(lnk);
    tabRet.push_back(ret);
    tabL2.push_back(l2);
    tabRedir.push_back(1'b0);
    tabTarget.push_back(64'd0);
  endtask

  task automatic addPlain(input logic [31:0] inst, input logic [classW-1:0] cls);
    addInst(inst, cls, 1'b0, 1'b0, 2'b00);
  endtask

  task automatic addRedirect(input logic [63:0] target);
    addInst(32'd0, '0, 1'b0, 1'b0, 2'b00);
    tabRedir[tabRedir.size()-1]   = 1'b1;
    tabTarget[tabTarget.size()-1] = target;
  endtask

  task automatic loadTable();
    addPlain(32'h00000085, clsBit(clsAlu)); // c.addi, c.li share a word
    addPlain(32'h0000428D, clsBit(clsAlu));
    addPlain(32'h00013503, clsBit(clsLoad));
    addPlain(32'h00813087, clsBit(clsLoad) | clsBit(clsLoadFpu)); // fld
    addPlain(32'h00004044, clsBit(clsLoad));
    addPlain(32'h00513823, clsBit(clsStore));
    addPlain(32'h00002404, clsBit(clsLoad) | clsBit(clsLoadFpu)); // c.fld
    addPlain(32'h00313027, clsBit(clsStore) | clsBit(clsStore2)); // fsd
    addPlain(32'h0000E404, clsBit(clsStore));
    addPlain(32'h0000A404, clsBit(clsStore) | clsBit(clsStore2)); // c.fsd
    addPlain(32'h00500093, clsBit(clsAlu));
    addPlain(32'h00331313, clsBit(clsShift));
    addPlain(32'h4283D393, clsBit(clsShift)); // srai with 6-bit shamt
    addPlain(32'h00008005, clsBit(clsShift));
    addPlain(32'h00008409, clsBit(clsShift));
    addPlain(32'h002081B3, clsBit(clsAlu));
    addPlain(32'h022081B3, clsBit(clsMul));
    addPlain(32'h4052523B, clsBit(clsShift)); // sraw
    addPlain(32'h0000880D, clsBit(clsAlu));
    addPlain(32'h00008C05, clsBit(clsAlu));
    addPlain(32'h123452B7, clsBit(clsAlu));
    addPlain(32'h00001317, clsBit(clsAlu));
    addPlain(32'h0010809B, clsBit(clsAlu));
    addPlain(32'h00002085, clsBit(clsAlu)); // c.addiw
    addPlain(32'h0000A021, clsBit(clsJump));
    addPlain(32'h023170D3, clsBit(clsFpu));
    addPlain(32'h223170C3, clsBit(clsFpu));
    addPlain(32'h00000073, clsBit(clsSys));
    addPlain(32'h0FF0000F, clsBit(clsSys));
    addPlain(32'h00000086, clsBit(clsShift));
    addPlain(32'h000060A2, clsBit(clsLoad));
    addPlain(32'h0000E406, clsBit(clsStore));
    addPlain(32'h000020A2, clsBit(clsLoad) | clsBit(clsLoadFpu));
    addPlain(32'h0000808A, clsBit(clsMul)); // c.mv
    addPlain(32'h0000908A, clsBit(clsAlu));
    addPlain(32'h00000800, clsBit(clsAlu));
    addRedirect(64'h1000);
    addPlain(32'h0100006F, clsBit(clsJump));
    addInst(32'h010000EF, clsBit(clsJump), 1'b1, 1'b0, 2'b01);
    addPlain(32'h00008302, clsBit(clsIndir));
    addInst(32'h010002EF, clsBit(clsJump), 1'b1, 1'b0, 2'b10);
    addInst(32'h000300E7, clsBit(clsIndir), 1'b1, 1'b0, 2'b01);
    addInst(32'h00008067, clsBit(clsIndir), 1'b0, 1'b1, 2'b01); // ret
    addInst(32'h00008082, clsBit(clsIndir), 1'b0, 1'b1, 2'b01);
    addInst(32'h00028067, clsBit(clsIndir), 1'b0, 1'b1, 2'b10);
    addInst(32'h00008282, clsBit(clsIndir), 1'b0, 1'b1, 2'b10);
    addPlain(32'h00030067, clsBit(clsIndir));
    addInst(32'h00009302, clsBit(clsIndir), 1'b1, 1'b0, 2'b01); // c.jalr
    addPlain(32'h00208463, clsBit(clsBranch));
    addPlain(32'h0000C011, clsBit(clsBranch));
    addPlain(32'h00009002, clsBit(clsSys));
    addPlain(32'h00013503, clsBit(clsLoad));
    addRedirect(64'h2002);
    addPlain(32'h002081B3, clsBit(clsAlu));
    addPlain(32'h0000808A, clsBit(clsMul));
    addInst(32'h010000EF, clsBit(clsJump), 1'b1, 1'b0, 2'b01);
    addPlain(32'h00000085, clsBit(clsAlu));
    addPlain(32'h0000908A, clsBit(clsAlu));
    addPlain(32'h022081B3, clsBit(clsMul));
    addRedirect(64'h3006);
    addPlain(32'h0000428D, clsBit(clsAlu));
    addPlain(32'h00004044, clsBit(clsLoad));
    addInst(32'h00008082, clsBit(clsIndir), 1'b0, 1'b1, 2'b01);
  endtask

  task automatic flushParcels();
    int k;
    if (parcelBuf.size() % 2 != 0) begin
      parcelBuf.push_back(16'h0003); // pad half inst never completed
      parcelTag.push_back(2'd0);
    end
    for (k = 0; k < parcelBuf.size(); k += 2) begin
      stimKind.push_back(1'b0);
      stimData.push_back({32'h0, parcelBuf[k+1], parcelBuf[k]});
      stimEmit.push_back(parcelTag[k] != 2'd0); // word completes an inst
      stimHold.push_back(parcelTag[k+1] == 2'd1); // whole rvc left in high parcel
    end
    parcelBuf.delete();
    parcelTag.delete();
  endtask

  task automatic packStream();
    int                i;
    logic [63:0]       pcNow;
    logic              comp;
    logic [classW-1:0] cls;
    pcNow = 64'd0;
    for (i = 0; i < tabInst.size(); i++) begin
      if (tabRedir[i]) begin
        flushParcels();
        stimKind.push_back(1'b1);
        stimData.push_back(tabTarget[i]);
        stimEmit.push_back(1'b0);
        stimHold.push_back(1'b0);
        pcNow = tabTarget[i];
        if (pcNow[1]) begin
          parcelBuf.push_back(16'h0001); // skipped low parcel
          parcelTag.push_back(2'd0);
        end
      end else begin
        comp = (tabInst[i][1:0] != 2'b11);
        cls = tabCls[i];
        cls[clsPos0] = (parcelBuf.size() % 2 == 0);
        expInst.push_back(comp ? {16'h0, tabInst[i][15:0]} : tabInst[i]);
        expCls.push_back(cls);
        expPc.push_back(pcNow);
        expLnk.push_back(tabLnk[i]);
        expRet.push_back(tabRet[i]);
        expL2.push_back(tabL2[i]);
        parcelBuf.push_back(tabInst[i][15:0]);
        parcelTag.push_back(comp ? 2'd1 : 2'd2);
        if (!comp) begin
          parcelBuf.push_back(tabInst[i][31:16]);
          parcelTag.push_back(2'd3);
        end
        pcNow = pcNow + (comp ? 64'd2 : 64'd4);
      end
    end
    flushParcels();
  endtask

  task automatic checkVal(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // outputs settle after the rising edge
  always @(negedge clk) begin
    if (!rst && instValid) begin
      if (checkIdx >= expInst.size()) begin
        errors++;
        $display("unexpected instruction %h at %0t ns", instOut, $time);
      end else begin
        checkVal("instOut", 64'(instOut), 64'(expInst[checkIdx]));
        checkVal("instPc", instPc, expPc[checkIdx]);
        checkVal("instClass", 64'(instClass), 64'(expCls[checkIdx]));
        checkVal("isLnk", 64'(isLnk), 64'(expLnk[checkIdx]));
        checkVal("isRet", 64'(isRet), 64'(expRet[checkIdx]));
        checkVal("lnk2", 64'(lnk2), 64'(expL2[checkIdx]));
        checkIdx++;
      end
    end
  end

  initial begin
    int limit;
    wait (tableReady);
    limit = tabInst.size() * 40 * 4;
    #(limit);
    $display("timeout: only %0d of %0d instructions seen after %0d ns",
             checkIdx, expInst.size(), limit);
    $display("Test failed");
    $finish;
  end

  initial begin
    int   n;
    int   g;
    int   gap;
    logic rdy;
    rst        = 1'b1;
    fetchValid = 1'b0;
    fetchWord  = 32'd0;
    redirect   = 1'b0;
    redirectPc = 64'd0;
    errors     = 0;
    checkIdx   = 0;
    tableReady = 1'b0;
    rndState   = 32'had2396eb;
    loadTable();
    packStream();
    tableReady = 1'b1;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    for (n = 0; n < stimKind.size(); n++) begin
      if (stimKind[n]) begin
        while (!fetchReady) begin // let a held compressed inst drain
          @(posedge clk);
          #1;
        end
        redirect   = 1'b1;
        redirectPc = stimData[n];
        @(posedge clk);
        #1;
        redirect = 1'b0;
      end else begin
        rndState = xorshift(rndState);
        gap = int'(rndState % 3);
        for (g = 0; g < gap; g++) begin
          @(posedge clk);
          #1;
        end
        fetchValid = 1'b1;
        fetchWord  = stimData[n][31:0];
        do begin
          rdy = fetchReady;
          @(posedge clk);
          #1;
        end while (!rdy);
        fetchValid = 1'b0;
        // one cycle after the word was taken
        checkVal("fetchReady", 64'(fetchReady), 64'(!stimHold[n]));
        checkVal("instValid", 64'(instValid), 64'(stimEmit[n]));
      end
    end
    wait (checkIdx == expInst.size());
    repeat (4) @(posedge clk);
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb/predecTop_sva.sv */
`timescale 1ns/1ns
`default_nettype none

module predecTopSva (
  input logic        clk,
  input logic        rst,
  input logic        fetchValid,
  input logic        fetchReady,
  input logic        instValid,
  input logic [63:0] instPc
);

  logic seenAccept;

  always_ff @(posedge clk) begin
    if (rst) seenAccept <= 1'b0;
    else if (fetchValid && fetchReady) seenAccept <= 1'b1;
  end

  assert property (@(posedge clk) rst |=> !instValid)
    else $error("instValid high after a reset cycle");

  assert property (@(posedge clk) disable iff (rst) !seenAccept |-> fetchReady)
    else $error("fetchReady low before any word was taken");

  assert property (@(posedge clk) disable iff (rst) !fetchReady |=> instValid)
    else $error("held compressed inst not emitted");

  assert property (@(posedge clk) disable iff (rst) instValid |-> !instPc[0])
    else $error("odd instPc");

endmodule

bind predecTop predecTopSva u_predecTopSva (
  .clk(clk), .rst(rst), .fetchValid(fetchValid), .fetchReady(fetchReady),
  .instValid(instValid), .instPc(instPc)
);

`default_nettype wire
